// ==== src/trap_pkg.sv ====
// Shared types and constants of the machine-mode trap and CSR unit; referenced by scoped names.
`default_nettype none

package trap_pkg;

    // privilege level, only user and machine are implemented.
    typedef logic [1:0] priv_t;

    localparam priv_t priv_u = 2'd0;
    localparam priv_t priv_m = 2'd3;

    // csr address as carried on the read and write ports.
    typedef logic [11:0] csr_addr_t;

    // machine trap setup.
    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_mie      = 12'h304;
    localparam csr_addr_t csr_mtvec    = 12'h305;

    // machine trap handling.
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mtval    = 12'h343;
    localparam csr_addr_t csr_mip      = 12'h344;

    // mstatus fields kept by this unit.
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    // mpp is two bits wide starting here.
    localparam int mstatus_mpp_lsb  = 11;

    // interrupt codes, also the bit positions in mie and mip.
    localparam int irq_msi = 3;
    localparam int irq_mti = 7;
    localparam int irq_mei = 11;

    // width of an interrupt code as it travels between units.
    localparam int irq_code_w = 4;

endpackage

`default_nettype wire

// ==== src/irq_pending.sv ====
// Interrupt pending register; samples the external interrupt lines on clk and holds mip.
`timescale 1ns/100ps
`default_nettype none

module irq_pending #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                ext_msip,
    input  logic                ext_mtip,
    input  logic                ext_meip,
    input  logic                csr_wr,
    input  trap_pkg::csr_addr_t csr_waddr,
    input  logic [xlen-1:0]     csr_wdata,
    output logic [xlen-1:0]     mip
);

    logic [2:0] ext_now;
    logic [2:0] ext_d;
    logic [2:0] toggle;
    logic       mip_msip;
    logic       mip_mtip;
    logic       mip_meip;
    logic       mip_wr;

    // bit order is {meip, mtip, msip}.
    assign ext_now = {ext_meip, ext_mtip, ext_msip};
    assign toggle  = ext_now ^ ext_d;
    assign mip_wr  = csr_wr && (csr_waddr == trap_pkg::csr_mip);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ext_d    <= 3'b000;
            mip_msip <= 1'b0;
            mip_mtip <= 1'b0;
            mip_meip <= 1'b0;
        end else begin
            ext_d <= ext_now;
            // a line change overrides a software write to msip.
            if (toggle[0]) begin
                mip_msip <= ext_msip;
            end else if (mip_wr) begin
                mip_msip <= csr_wdata[trap_pkg::irq_msi];
            end
            if (toggle[1]) begin
                mip_mtip <= ext_mtip;
            end
            if (toggle[2]) begin
                mip_meip <= ext_meip;
            end
        end
    end

    always_comb begin
        mip                    = '0;
        mip[trap_pkg::irq_msi] = mip_msip;
        mip[trap_pkg::irq_mti] = mip_mtip;
        mip[trap_pkg::irq_mei] = mip_meip;
    end

endmodule

`default_nettype wire

// ==== src/irq_select.sv ====
// Interrupt arbiter; decides whether a pending, enabled interrupt is taken and which code wins.
`timescale 1ns/100ps
`default_nettype none

module irq_select #(
    parameter int xlen = 32
) (
    input  trap_pkg::priv_t                  prv,
    input  logic                             mstatus_mie,
    input  logic                             trap_en,
    input  logic [xlen-1:0]                  mip,
    input  logic [xlen-1:0]                  mie,
    output logic                             irq_take,
    output logic [trap_pkg::irq_code_w-1:0]  irq_code
);

    logic [xlen-1:0] pend_en;
    logic            glob_en;
    logic            any_irq;

    assign pend_en = mip & mie;

    // user mode can always be interrupted by machine interrupts.
    assign glob_en = (prv == trap_pkg::priv_m) ? mstatus_mie : 1'b1;

    assign any_irq = pend_en[trap_pkg::irq_mei] |
                     pend_en[trap_pkg::irq_msi] |
                     pend_en[trap_pkg::irq_mti];

    // a synchronous trap in the same cycle always wins.
    assign irq_take = glob_en && any_irq && !trap_en;

    // fixed priority: external, then software, then timer.
    always_comb begin
        if (pend_en[trap_pkg::irq_mei]) begin
            irq_code = trap_pkg::irq_code_w'(trap_pkg::irq_mei);
        end else if (pend_en[trap_pkg::irq_msi]) begin
            irq_code = trap_pkg::irq_code_w'(trap_pkg::irq_msi);
        end else begin
            irq_code = trap_pkg::irq_code_w'(trap_pkg::irq_mti);
        end
    end

endmodule

`default_nettype wire

// ==== src/trap_state.sv ====
// Trap state unit; holds privilege, mstatus, mtvec, mepc, mcause and mtval and forms the vector.
`timescale 1ns/100ps
`default_nettype none

module trap_state #(
    parameter int xlen = 32
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            trap_en,
    input  logic                            mret,
    input  logic                            irq_take,
    input  logic [trap_pkg::irq_code_w-1:0] irq_code,
    input  logic [xlen-1:0]                 trap_epc,
    input  logic [xlen-1:0]                 trap_cause,
    input  logic [xlen-1:0]                 trap_val,
    input  logic                            csr_wr,
    input  trap_pkg::csr_addr_t             csr_waddr,
    input  logic [xlen-1:0]                 csr_wdata,
    output trap_pkg::priv_t                 prv,
    output logic                            mstatus_mie,
    output logic [xlen-1:0]                 mstatus,
    output logic [xlen-1:0]                 mtvec,
    output logic [xlen-1:0]                 mepc,
    output logic [xlen-1:0]                 mcause,
    output logic [xlen-1:0]                 mtval,
    output logic [xlen-1:0]                 trap_vec,
    output logic [xlen-1:0]                 cause,
    output logic [xlen-1:0]                 tval
);

    logic            mstatus_mpie;
    trap_pkg::priv_t mstatus_mpp;
    trap_pkg::priv_t wr_mpp;
    logic            entry;
    logic            wr_ok;
    logic [xlen-1:0] irq_cause;
    logic [xlen-1:0] vec_off;

    assign entry = trap_en || irq_take;

    // software writes only land in a cycle with no trap, interrupt or mret.
    assign wr_ok = csr_wr && !entry && !mret;

    // mpp is warl, anything but machine is stored as user.
    assign wr_mpp = (csr_wdata[trap_pkg::mstatus_mpp_lsb +: 2] == trap_pkg::priv_m) ?
                    trap_pkg::priv_m : trap_pkg::priv_u;

    always_comb begin
        irq_cause                        = '0;
        irq_cause[xlen-1]                = 1'b1;
        irq_cause[trap_pkg::irq_code_w-1:0] = irq_code;
    end

    assign cause = trap_en  ? trap_cause :
                   irq_take ? irq_cause  : '0;
    assign tval  = trap_en  ? trap_val   : '0;

    // vectored mode adds four times the code, only for interrupts.
    assign vec_off  = (irq_take && mtvec[0]) ? xlen'({irq_code, 2'b00}) : '0;
    assign trap_vec = {mtvec[xlen-1:2], 2'b00} + vec_off;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prv          <= trap_pkg::priv_m;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= trap_pkg::priv_u;
        end else if (entry) begin
            mstatus_mpp  <= prv;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            prv          <= trap_pkg::priv_m;
        end else if (mret) begin
            prv          <= mstatus_mpp;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= trap_pkg::priv_u;
        end else if (wr_ok && csr_waddr == trap_pkg::csr_mstatus) begin
            mstatus_mie  <= csr_wdata[trap_pkg::mstatus_mie_bit];
            mstatus_mpie <= csr_wdata[trap_pkg::mstatus_mpie_bit];
            mstatus_mpp  <= wr_mpp;
        end
    end

    // trap record, captured on entry.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (entry) begin
            mepc   <= trap_epc;
            mcause <= cause;
            mtval  <= tval;
        end else if (wr_ok) begin
            if (csr_waddr == trap_pkg::csr_mepc) begin
                mepc <= csr_wdata & ~xlen'(3);
            end
            if (csr_waddr == trap_pkg::csr_mcause) begin
                mcause <= csr_wdata;
            end
            if (csr_waddr == trap_pkg::csr_mtval) begin
                mtval <= csr_wdata;
            end
        end
    end

    // bit 1 of mtvec is reserved and reads zero.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtvec <= '0;
        end else if (wr_ok && csr_waddr == trap_pkg::csr_mtvec) begin
            mtvec <= csr_wdata & ~xlen'(2);
        end
    end

    always_comb begin
        mstatus                                    = '0;
        mstatus[trap_pkg::mstatus_mie_bit]         = mstatus_mie;
        mstatus[trap_pkg::mstatus_mpie_bit]        = mstatus_mpie;
        mstatus[trap_pkg::mstatus_mpp_lsb +: 2]    = mstatus_mpp;
    end

endmodule

`default_nettype wire

// ==== src/csr_regs.sv ====
// CSR register file; holds mie and mscratch and decodes combinational CSR reads.
`timescale 1ns/100ps
`default_nettype none

module csr_regs #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                csr_wr,
    input  trap_pkg::csr_addr_t csr_waddr,
    input  logic [xlen-1:0]     csr_wdata,
    input  trap_pkg::csr_addr_t csr_raddr,
    input  logic [xlen-1:0]     mstatus,
    input  logic [xlen-1:0]     mtvec,
    input  logic [xlen-1:0]     mepc,
    input  logic [xlen-1:0]     mcause,
    input  logic [xlen-1:0]     mtval,
    input  logic [xlen-1:0]     mip,
    output logic [xlen-1:0]     mie,
    output logic [xlen-1:0]     csr_rdata
);

    logic            mie_msie;
    logic            mie_mtie;
    logic            mie_meie;
    logic [xlen-1:0] mscratch;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
            mscratch <= '0;
        end else if (csr_wr) begin
            // only the three machine enables exist, other bits are dropped.
            if (csr_waddr == trap_pkg::csr_mie) begin
                mie_msie <= csr_wdata[trap_pkg::irq_msi];
                mie_mtie <= csr_wdata[trap_pkg::irq_mti];
                mie_meie <= csr_wdata[trap_pkg::irq_mei];
            end
            if (csr_waddr == trap_pkg::csr_mscratch) begin
                mscratch <= csr_wdata;
            end
        end
    end

    always_comb begin
        mie                    = '0;
        mie[trap_pkg::irq_msi] = mie_msie;
        mie[trap_pkg::irq_mti] = mie_mtie;
        mie[trap_pkg::irq_mei] = mie_meie;
    end

    // unimplemented addresses such as misa read as zero.
    always_comb begin
        case (csr_raddr)
            trap_pkg::csr_mstatus:  csr_rdata = mstatus;
            trap_pkg::csr_mie:      csr_rdata = mie;
            trap_pkg::csr_mtvec:    csr_rdata = mtvec;
            trap_pkg::csr_mscratch: csr_rdata = mscratch;
            trap_pkg::csr_mepc:     csr_rdata = mepc;
            trap_pkg::csr_mcause:   csr_rdata = mcause;
            trap_pkg::csr_mtval:    csr_rdata = mtval;
            trap_pkg::csr_mip:      csr_rdata = mip;
            default:                csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/trap_csr_top.sv ====
// Top level of the machine-mode trap and CSR unit; connects pending, select, state and CSR blocks.
`timescale 1ns/100ps
`default_nettype none

module trap_csr_top #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                ext_msip,
    input  logic                ext_mtip,
    input  logic                ext_meip,
    input  logic                trap_en,
    input  logic [xlen-1:0]     trap_epc,
    input  logic [xlen-1:0]     trap_cause,
    input  logic [xlen-1:0]     trap_val,
    input  logic                mret,
    input  logic                csr_wr,
    input  trap_pkg::csr_addr_t csr_waddr,
    input  trap_pkg::csr_addr_t csr_raddr,
    input  logic [xlen-1:0]     csr_wdata,
    output trap_pkg::priv_t     prv,
    output logic                irq_trigger,
    output logic [xlen-1:0]     cause,
    output logic [xlen-1:0]     tval,
    output logic [xlen-1:0]     trap_vec,
    output logic [xlen-1:0]     ret_epc,
    output logic                eret_en,
    output logic [xlen-1:0]     csr_rdata
);

    logic [xlen-1:0]                 mip;
    logic [xlen-1:0]                 mie;
    logic [xlen-1:0]                 mstatus;
    logic [xlen-1:0]                 mtvec;
    logic [xlen-1:0]                 mepc;
    logic [xlen-1:0]                 mcause;
    logic [xlen-1:0]                 mtval;
    logic                            mstatus_mie;
    logic [trap_pkg::irq_code_w-1:0] irq_code;

    // mret is dropped when a trap arrives in the same cycle.
    assign eret_en = mret && !trap_en;
    assign ret_epc = mepc;

    irq_pending #(.xlen(xlen)) u_irq_pending (
        .clk, .rstn, .ext_msip, .ext_mtip, .ext_meip,
        .csr_wr, .csr_waddr, .csr_wdata, .mip
    );

    irq_select #(.xlen(xlen)) u_irq_select (
        .prv, .mstatus_mie, .trap_en, .mip, .mie,
        .irq_take (irq_trigger),
        .irq_code
    );

    trap_state #(.xlen(xlen)) u_trap_state (
        .clk, .rstn, .trap_en, .mret,
        .irq_take (irq_trigger),
        .irq_code, .trap_epc, .trap_cause, .trap_val,
        .csr_wr, .csr_waddr, .csr_wdata,
        .prv, .mstatus_mie, .mstatus, .mtvec, .mepc, .mcause, .mtval,
        .trap_vec, .cause, .tval
    );

    csr_regs #(.xlen(xlen)) u_csr_regs (
        .clk, .rstn, .csr_wr, .csr_waddr, .csr_wdata, .csr_raddr,
        .mstatus, .mtvec, .mepc, .mcause, .mtval, .mip,
        .mie, .csr_rdata
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// Clock and reset source for the testbench; 100 ns clock, reset held low for five cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release a little after the edge so no flop sees it change at the edge.
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(period / 10);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
// Output checker of the testbench; compares the DUT outputs with the trace values every cycle.
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            check_en,
    input  logic            test_end,
    input  int              test_id,
    input  logic [7:0]      exp_mask,
    input  logic [xlen-1:0] exp_rdata,
    input  logic [1:0]      exp_prv,
    input  logic            exp_irq,
    input  logic            exp_eret,
    input  logic [xlen-1:0] exp_cause,
    input  logic [xlen-1:0] exp_tval,
    input  logic [xlen-1:0] exp_vec,
    input  logic [xlen-1:0] exp_repc,
    input  logic [xlen-1:0] csr_rdata,
    input  logic [1:0]      prv,
    input  logic            irq_trigger,
    input  logic            eret_en,
    input  logic [xlen-1:0] cause,
    input  logic [xlen-1:0] tval,
    input  logic [xlen-1:0] trap_vec,
    input  logic [xlen-1:0] ret_epc,
    output int              error_count,
    output int              check_count,
    output int              test_count
);

    int test_errors;

    task automatic compare(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    // inputs change 10 ns after the rising edge, so outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (check_en) begin
            // one mask bit per output, bit 0 is csr_rdata.
            if (exp_mask[0]) compare("csr_rdata", csr_rdata, exp_rdata);
            if (exp_mask[1]) compare("prv", xlen'(prv), xlen'(exp_prv));
            if (exp_mask[2]) compare("irq_trigger", xlen'(irq_trigger), xlen'(exp_irq));
            if (exp_mask[3]) compare("eret_en", xlen'(eret_en), xlen'(exp_eret));
            if (exp_mask[4]) compare("cause", cause, exp_cause);
            if (exp_mask[5]) compare("tval", tval, exp_tval);
            if (exp_mask[6]) compare("trap_vec", trap_vec, exp_vec);
            if (exp_mask[7]) compare("ret_epc", ret_epc, exp_repc);
        end
        if (test_end) begin
            test_count++;
            $display("test %0d %s, %0d mismatches", test_id,
                     (test_errors == 0) ? "ok" : "FAILED", test_errors);
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== dv/trap_csr_sva.sv ====
// Concurrent checks on the trap and CSR unit; attached to trap_csr_top with bind.
`timescale 1ns/100ps
`default_nettype none

module trap_csr_sva (
    input logic            clk,
    input logic            rstn,
    input logic            trap_en,
    input logic            irq_trigger,
    input logic            eret_en,
    input trap_pkg::priv_t prv
);

    int fail_count;

    // a synchronous trap masks both the interrupt and the return.
    a_irq_masked_by_trap: assert property (
        @(posedge clk) disable iff (!rstn) trap_en |-> !irq_trigger
    ) else begin
        fail_count++;
        $error("irq_trigger high in a trap cycle");
    end

    a_eret_masked_by_trap: assert property (
        @(posedge clk) disable iff (!rstn) trap_en |-> !eret_en
    ) else begin
        fail_count++;
        $error("eret_en high in a trap cycle");
    end

    // only user and machine levels exist.
    a_prv_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        (prv == trap_pkg::priv_m) || (prv == trap_pkg::priv_u)
    ) else begin
        fail_count++;
        $error("illegal privilege level %0d", prv);
    end

endmodule

bind trap_csr_top trap_csr_sva u_sva (
    .clk, .rstn, .trap_en, .irq_trigger, .eret_en, .prv
);

`default_nettype wire

// ==== dv/tb_top.sv ====
// Testbench top; reads the step trace, drives the trap and CSR unit and reports the result.
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int    xlen          = 32;
    localparam int    drive_delay   = 10;
    localparam int    reset_timeout = 20;
    localparam int    max_lines     = 200;
    localparam string trace_file    = "dv/trap_trace.txt";

    logic                clk;
    logic                rstn;
    logic                ext_msip;
    logic                ext_mtip;
    logic                ext_meip;
    logic                trap_en;
    logic [xlen-1:0]     trap_epc;
    logic [xlen-1:0]     trap_cause;
    logic [xlen-1:0]     trap_val;
    logic                mret;
    logic                csr_wr;
    trap_pkg::csr_addr_t csr_waddr;
    trap_pkg::csr_addr_t csr_raddr;
    logic [xlen-1:0]     csr_wdata;
    trap_pkg::priv_t     prv;
    logic                irq_trigger;
    logic [xlen-1:0]     cause;
    logic [xlen-1:0]     tval;
    logic [xlen-1:0]     trap_vec;
    logic [xlen-1:0]     ret_epc;
    logic                eret_en;
    logic [xlen-1:0]     csr_rdata;

    logic                check_en;
    logic                test_end;
    int                  test_id;
    // trace fields after the operation name are p1 p2 p3 raddr mask and eight expected values.
    logic [31:0]         fields [13];
    // fields of the step being driven, as seen by the checker.
    logic [31:0]         f [13];
    int                  error_count;
    int                  check_count;
    int                  test_count;
    int                  bad_ops;

    tb_clock #(.period(100), .reset_cycles(5)) u_clock (.clk, .rstn);

    trap_csr_top #(.xlen(xlen)) uut (
        .clk, .rstn, .ext_msip, .ext_mtip, .ext_meip,
        .trap_en, .trap_epc, .trap_cause, .trap_val, .mret,
        .csr_wr, .csr_waddr, .csr_raddr, .csr_wdata,
        .prv, .irq_trigger, .cause, .tval, .trap_vec, .ret_epc, .eret_en, .csr_rdata
    );

    tb_checker #(.xlen(xlen)) u_checker (
        .clk, .check_en, .test_end, .test_id,
        .exp_mask(f[4][7:0]), .exp_rdata(f[5]), .exp_prv(f[6][1:0]),
        .exp_irq(f[7][0]), .exp_eret(f[8][0]), .exp_cause(f[9]), .exp_tval(f[10]),
        .exp_vec(f[11]), .exp_repc(f[12]),
        .csr_rdata, .prv, .irq_trigger, .eret_en, .cause, .tval, .trap_vec, .ret_epc,
        .error_count, .check_count, .test_count
    );

    // one trace step is applied shortly after the rising edge and its strobes last one cycle.
    task automatic drive_step(input string op, input logic [31:0] p1, input logic [31:0] p2,
                              input logic [31:0] p3, input logic [31:0] raddr);
        @(posedge clk);
        #(drive_delay);
        f          = fields;
        csr_wr     = 1'b0;
        trap_en    = 1'b0;
        mret       = 1'b0;
        trap_epc   = '0;
        trap_cause = '0;
        trap_val   = '0;
        check_en   = 1'b1;
        test_end   = 1'b0;
        csr_raddr  = raddr[11:0];
        case (op)
            "write": begin
                csr_wr    = 1'b1;
                csr_waddr = p1[11:0];
                csr_wdata = p2;
            end
            "trap": begin
                trap_en    = 1'b1;
                trap_epc   = p1;
                trap_cause = p2;
                trap_val   = p3;
            end
            // p1 is the pc the pipeline would save on an interrupt.
            "idle": trap_epc = p1;
            "mret": mret = 1'b1;
            "ext": {ext_meip, ext_mtip, ext_msip} = p1[2:0];
            "read": check_en = 1'b1;
            "done": begin
                check_en = 1'b0;
                test_end = 1'b1;
                test_id  = int'(p1);
            end
            default: begin
                $display("unknown operation %s in the trace", op);
                check_en = 1'b0;
                bad_ops++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    n;
        int    cycles;
        int    lines;
        bit    failed;
        string line;
        string op;

        {ext_msip, ext_mtip, ext_meip, trap_en, mret, csr_wr} = '0;
        {trap_epc, trap_cause, trap_val, csr_wdata} = '0;
        csr_waddr = '0;
        csr_raddr = '0;
        check_en  = 1'b0;
        test_end  = 1'b0;
        test_id   = 0;
        failed    = 1'b0;
        foreach (f[i]) f[i] = '0;

        cycles = 0;
        while (rstn !== 1'b1 && cycles < reset_timeout) begin
            @(posedge clk);
            cycles++;
        end

        if (rstn !== 1'b1) begin
            $display("reset was not released within %0d cycles", reset_timeout);
            failed = 1'b1;
        end else begin
            fd = $fopen(trace_file, "r");
            if (fd == 0) begin
                $display("could not open the trace file %s", trace_file);
                failed = 1'b1;
            end else begin
                lines = 0;
                while (!$feof(fd) && lines < max_lines) begin
                    line = "";
                    void'($fgets(line, fd));
                    lines++;
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", op,
                                fields[0], fields[1], fields[2], fields[3], fields[4],
                                fields[5], fields[6], fields[7], fields[8], fields[9],
                                fields[10], fields[11], fields[12]);
                    if (n == 14) begin
                        drive_step(op, fields[0], fields[1], fields[2], fields[3]);
                    end else if (n > 0 && op.getc(0) != "#") begin
                        $display("trace line %0d could not be parsed", lines);
                        bad_ops++;
                    end
                end
                if (!$feof(fd)) begin
                    $display("trace did not end within %0d lines", max_lines);
                    failed = 1'b1;
                end
                $fclose(fd);
                // let the checker see the last step.
                @(posedge clk);
            end
        end

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count,
                 error_count + bad_ops + uut.u_sva.fail_count);
        if (failed || error_count != 0 || bad_ops != 0 || test_count == 0 ||
            uut.u_sva.fail_count != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/trap_trace.txt ====
# one step per line, all numbers hex: op p1 p2 p3 raddr mask, then the expected values
# rdata prv irq_trigger eret_en cause tval trap_vec ret_epc; mask bit i enables value i
read 0 0 0 300 ff 0 3 0 0 0 0 0 0
read 0 0 0 304 0f 0 3 0 0 0 0 0 0
read 0 0 0 305 0f 0 3 0 0 0 0 0 0
read 0 0 0 340 0f 0 3 0 0 0 0 0 0
read 0 0 0 341 0f 0 3 0 0 0 0 0 0
read 0 0 0 342 0f 0 3 0 0 0 0 0 0
read 0 0 0 343 0f 0 3 0 0 0 0 0 0
read 0 0 0 344 0f 0 3 0 0 0 0 0 0
done 1 0 0 0 00 0 0 0 0 0 0 0 0
write 305 1007 0 0 0e 0 3 0 0 0 0 0 0
write 341 2003 0 305 4f 1005 3 0 0 0 0 1004 0
write 304 ffffffff 0 341 8f 2000 3 0 0 0 0 0 2000
write 344 ffffffff 0 304 0f 888 3 0 0 0 0 0 0
write 344 0 0 344 0f 8 3 0 0 0 0 0 0
write 340 deadbeef 0 344 0f 0 3 0 0 0 0 0 0
read 0 0 0 340 0f deadbeef 3 0 0 0 0 0 0
read 0 0 0 301 0f 0 3 0 0 0 0 0 0
done 2 0 0 0 00 0 0 0 0 0 0 0 0
write 300 8 0 0 0e 0 3 0 0 0 0 0 0
trap 400 2 12345678 300 ff 8 3 0 0 2 12345678 1004 2000
read 0 0 0 341 8f 400 3 0 0 0 0 0 400
read 0 0 0 342 0f 2 3 0 0 0 0 0 0
read 0 0 0 343 0f 12345678 3 0 0 0 0 0 0
read 0 0 0 300 0f 1880 3 0 0 0 0 0 0
done 3 0 0 0 00 0 0 0 0 0 0 0 0
write 300 8 0 0 0e 0 3 0 0 0 0 0 0
ext 6 0 0 304 0f 888 3 0 0 0 0 0 0
idle 500 0 0 344 7f 880 3 1 0 8000000b 0 1030 0
ext 0 0 0 342 8f 8000000b 3 0 0 0 0 0 500
read 0 0 0 300 0f 1880 3 0 0 0 0 0 0
done 4 0 0 0 00 0 0 0 0 0 0 0 0
write 300 80 0 344 0f 0 3 0 0 0 0 0 0
write 341 600 0 300 0f 80 3 0 0 0 0 0 0
mret 0 0 0 341 8f 600 3 0 1 0 0 0 600
read 0 0 0 300 0f 88 0 0 0 0 0 0 0
done 5 0 0 0 00 0 0 0 0 0 0 0 0
write 300 0 0 0 0e 0 0 0 0 0 0 0 0
ext 1 0 0 300 0f 0 0 0 0 0 0 0 0
idle 700 0 0 344 7f 8 0 1 0 80000003 0 1010 0
ext 0 0 0 342 8f 80000003 3 0 0 0 0 0 700
read 0 0 0 300 0f 0 3 0 0 0 0 0 0
done 6 0 0 0 00 0 0 0 0 0 0 0 0

// ==== flist.f ====
src/trap_pkg.sv
src/irq_pending.sv
src/irq_select.sv
src/trap_state.sv
src/csr_regs.sv
src/trap_csr_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/trap_csr_sva.sv
dv/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx 'Testbench passed' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
